/* rtl/addressUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module addressUnit (
    input  logic                      clk25,
    input  logic                      arstN,
    input  logic                      ipStep,
    input  logic                      eaLoad,
    input  logic                      eaStep,
    input  logic                      eaBack,
    input  logic                      useEa,
    input  cpuPkg::regIdxT            rmField,
    input  logic [cpuPkg::dataW-1:0]  bx,
    input  logic [cpuPkg::dataW-1:0]  si,
    input  logic [cpuPkg::dataW-1:0]  di,
    input  logic [cpuPkg::dataW-1:0]  bp,
    output logic [cpuPkg::dataW-1:0]  addr
);

    logic [cpuPkg::dataW-1:0] ip;
    logic [cpuPkg::dataW-1:0] ea;
    logic [cpuPkg::dataW-1:0] pairSum;

    // Register pair for mod = 00, no displacement
    always_comb begin
        case (rmField)
            3'd0:    pairSum = bx + si;
            3'd1:    pairSum = bx + di;
            3'd2:    pairSum = bp + si;
            3'd3:    pairSum = bp + di;
            3'd4:    pairSum = si;
            3'd5:    pairSum = di;
            3'd6:    pairSum = bp;                  // Direct address form not kept
            default: pairSum = bx;
        endcase
    end

    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) begin
            ip <= cpuPkg::ipReset;
            ea <= '0;
        end else begin
            if (ipStep) ip <= ip + 1'b1;
            if (eaLoad) ea <= pairSum;
            else if (eaStep) ea <= ea + 1'b1;       // High byte
            else if (eaBack) ea <= ea - 1'b1;
        end
    end

    assign addr = useEa ? ea : ip;                  // Same cycle as the request

endmodule

`default_nettype wire

/* rtl/aluPkg.sv */
`default_nettype none

package aluPkg;

    // ALU operations, same as opcode bits 5:3
    typedef logic [2:0] aluOpT;

    localparam aluOpT aluAdd = 3'd0;
    localparam aluOpT aluOr  = 3'd1;
    localparam aluOpT aluAdc = 3'd2;
    localparam aluOpT aluSbb = 3'd3;
    localparam aluOpT aluAnd = 3'd4;
    localparam aluOpT aluSub = 3'd5;
    localparam aluOpT aluXor = 3'd6;
    localparam aluOpT aluCmp = 3'd7;                // SUB without write-back

    // Flag bit positions ----------------
    localparam int flagCf = 0;
    localparam int flagPf = 2;
    localparam int flagAf = 4;
    localparam int flagZf = 6;
    localparam int flagSf = 7;
    localparam int flagOf = 11;

    // Flags word, whole or bit by bit
    typedef union packed {
        logic [11:0] raw;
        struct packed {
            logic of;
            logic df;
            logic intr;
            logic tf;
            logic sf;
            logic zf;
            logic rsv5;
            logic af;
            logic rsv3;
            logic pf;
            logic rsv1;
            logic cf;
        } flag;
    } flagsT;

endpackage

`default_nettype wire

/* rtl/aluUnit.sv */
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  logic                      clk25,
    input  logic                      arstN,
    input  logic [cpuPkg::byteW-1:0]  rdData,
    aluCtrlIf.alu                     ac,
    regPortIf.data                    rp,
    output logic [cpuPkg::byteW-1:0]  wrData
);

    logic [cpuPkg::dataW-1:0] opReg;                // reg field side
    logic [cpuPkg::dataW-1:0] opRm;                 // rm side, memory or immediate
    logic [cpuPkg::dataW-1:0] op1;                  // Destination
    logic [cpuPkg::dataW-1:0] op2;
    logic [cpuPkg::dataW:0]   sum;                  // Extra bit is carry or borrow
    logic isArith;
    logic isSub;
    logic s1;
    logic s2;
    logic sr;
    logic carry;
    logic ovf;
    aluPkg::flagsT flagsQ;
    aluPkg::flagsT nextFlags;

    // Operand latches -------------------
    always_ff @(posedge clk25) begin
        if (ac.loadReg) opReg <= rp.rdValue;
        if (ac.loadLow && ac.loadHigh) opRm <= rp.rdValue;     // rm is a register
        else if (ac.loadLow) opRm <= {{cpuPkg::byteW{1'b0}}, rdData};
        else if (ac.loadHigh) opRm[cpuPkg::dataW-1:cpuPkg::byteW] <= rdData;
    end

    assign op1 = ac.dir ? opReg : opRm;
    assign op2 = ac.dir ? opRm : opReg;

    always_comb begin
        case (ac.op)
            aluPkg::aluAdd: sum = {1'b0, op1} + {1'b0, op2};
            aluPkg::aluOr:  sum = {1'b0, op1 | op2};
            aluPkg::aluAdc: sum = {1'b0, op1} + {1'b0, op2} + flagsQ.flag.cf;
            aluPkg::aluSbb: sum = {1'b0, op1} - {1'b0, op2} - flagsQ.flag.cf;
            aluPkg::aluAnd: sum = {1'b0, op1 & op2};
            aluPkg::aluXor: sum = {1'b0, op1 ^ op2};
            default:        sum = {1'b0, op1} - {1'b0, op2};   // SUB, CMP
        endcase
    end

    // Flags -----------------------------
    assign isArith = !(ac.op inside {aluPkg::aluOr, aluPkg::aluAnd, aluPkg::aluXor});
    assign isSub   = ac.op inside {aluPkg::aluSbb, aluPkg::aluSub, aluPkg::aluCmp};
    assign s1      = ac.wide ? op1[15] : op1[7];   // Sign bits at byte or word width
    assign s2      = ac.wide ? op2[15] : op2[7];
    assign sr      = ac.wide ? sum[15] : sum[7];
    assign carry   = ac.wide ? sum[16] : sum[8];
    assign ovf     = isSub ? (s1 ^ s2) & (s1 ^ sr) : ~(s1 ^ s2) & (s1 ^ sr);

    always_comb begin
        nextFlags = flagsQ;                         // DF, IF, TF kept
        nextFlags.raw[aluPkg::flagCf] = isArith & carry;
        nextFlags.raw[aluPkg::flagPf] = ~^sum[7:0]; // Low byte only
        nextFlags.raw[aluPkg::flagAf] = isArith & (op1[4] ^ op2[4] ^ sum[4]);
        nextFlags.raw[aluPkg::flagZf] = ac.wide ? sum[15:0] == '0 : sum[7:0] == '0;
        nextFlags.raw[aluPkg::flagSf] = sr;
        nextFlags.raw[aluPkg::flagOf] = isArith & ovf;
    end

    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) flagsQ.raw <= '0;
        else if (ac.commit) flagsQ <= nextFlags;
    end

    assign ac.result = sum[cpuPkg::dataW-1:0];
    assign rp.wrValue = ac.result;
    assign wrData = ac.wrHigh ? ac.result[15:8] : ac.result[7:0];

endmodule

`default_nettype wire

/* rtl/cpuIfs.sv */
`timescale 1ns/1ps
`default_nettype none

// Register file port, one access per cycle
interface regPortIf;
    cpuPkg::regIdxT              idx;       // x86 register number
    logic                        wide;      // 1 = word, 0 = byte
    logic                        wrEn;      // Write at rising edge
    logic [cpuPkg::dataW-1:0]    wrValue;
    logic [cpuPkg::dataW-1:0]    rdValue;   // Zero extended for bytes

    modport ctrl (output idx, output wide, output wrEn);
    modport regs (input idx, input wide, input wrEn, input wrValue, output rdValue);
    modport data (output wrValue, input rdValue);
endinterface

// ALU control from the sequencer
interface aluCtrlIf;
    aluPkg::aluOpT               op;
    logic                        wide;
    logic                        dir;       // 1 = reg is destination
    logic                        loadLow;   // Both with loadHigh = rm register
    logic                        loadHigh;
    logic                        loadReg;   // reg side operand from rdValue
    logic                        commit;    // Store flags
    logic                        wrHigh;    // Bus byte select
    logic [cpuPkg::dataW-1:0]    result;

    modport ctrl (output op, output wide, output dir, output loadLow, output loadHigh,
                  output loadReg, output commit, output wrHigh);
    modport alu (input op, input wide, input dir, input loadLow, input loadHigh,
                 input loadReg, input commit, input wrHigh, output result);
endinterface

`default_nettype wire

/* rtl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    // Widths ----------------------------
    localparam int dataW = 16;                      // Register and address word
    localparam int byteW = 8;                       // Bus byte

    // Reset state
    localparam logic [dataW-1:0] ipReset = 16'hFFF0;
    // AX, CX, DX, BX, SP, BP, SI, DI
    localparam logic [dataW-1:0] regReset [8] = '{
        16'h0605, 16'h1245, 16'h64EA, 16'hE004,
        16'h0000, 16'h0000, 16'h1234, 16'h0000
    };

    typedef logic [2:0] regIdxT;                    // reg or rm field of ModRM

    // Fixed register indices
    localparam regIdxT regAx = 3'd0;                // AL when byte wide
    localparam regIdxT regBx = 3'd3;
    localparam regIdxT regBp = 3'd5;
    localparam regIdxT regSi = 3'd6;
    localparam regIdxT regDi = 3'd7;

    // Opcode patterns ------------------
    localparam logic [byteW-1:0] aluRmMask  = 8'b1100_0100;   // 00_ooo_0dw
    localparam logic [byteW-1:0] aluRmVal   = 8'b0000_0000;
    localparam logic [byteW-1:0] accImmMask = 8'b1100_0110;   // 00_ooo_10w
    localparam logic [byteW-1:0] accImmVal  = 8'b0000_0100;
    localparam logic [1:0]       modReg     = 2'b11;          // rm names a register

    // Sequencer states
    localparam logic [3:0] stFetch  = 4'd0;
    localparam logic [3:0] stModrm  = 4'd1;
    localparam logic [3:0] stOpReg  = 4'd2;         // reg field operand
    localparam logic [3:0] stOpRm   = 4'd3;         // rm register operand
    localparam logic [3:0] stOpLow  = 4'd4;         // Memory low byte
    localparam logic [3:0] stOpHigh = 4'd5;
    localparam logic [3:0] stExec   = 4'd6;
    localparam logic [3:0] stWrLow  = 4'd7;
    localparam logic [3:0] stWrHigh = 4'd8;
    localparam logic [3:0] stImmLow = 4'd9;
    localparam logic [3:0] stImmHigh = 4'd10;

endpackage

`default_nettype wire

/* rtl/cpuTop.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTop (
    input  logic                      clk25,
    input  logic                      arstN,
    input  logic [cpuPkg::byteW-1:0]  rdData,       // Valid in the addr cycle
    output logic [cpuPkg::dataW-1:0]  addr,
    output logic [cpuPkg::byteW-1:0]  wrData,
    output logic                      wrEn
);

    regPortIf rp ();
    aluCtrlIf ac ();

    // Address unit requests
    logic ipStep;
    logic eaLoad;
    logic eaStep;
    logic eaBack;
    logic useEa;
    cpuPkg::regIdxT rmField;

    // Pair pointers ---------------------
    logic [cpuPkg::dataW-1:0] bx;
    logic [cpuPkg::dataW-1:0] si;
    logic [cpuPkg::dataW-1:0] di;
    logic [cpuPkg::dataW-1:0] bp;

    sequencer uSeq (
        .clk25, .arstN, .rdData, .rp(rp.ctrl), .ac(ac.ctrl),
        .ipStep, .eaLoad, .eaStep, .eaBack, .useEa, .rmField, .wrEn
    );

    addressUnit uAddr (
        .clk25, .arstN, .ipStep, .eaLoad, .eaStep, .eaBack, .useEa,
        .rmField, .bx, .si, .di, .bp, .addr
    );

    regFile uRegs (.clk25, .arstN, .rp(rp.regs), .bx, .si, .di, .bp);

    aluUnit uAlu (.clk25, .arstN, .rdData, .ac(ac.alu), .rp(rp.data), .wrData);

endmodule

`default_nettype wire

/* rtl/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                      clk25,
    input  logic                      arstN,
    regPortIf.regs                    rp,
    output logic [cpuPkg::dataW-1:0]  bx,
    output logic [cpuPkg::dataW-1:0]  si,
    output logic [cpuPkg::dataW-1:0]  di,
    output logic [cpuPkg::dataW-1:0]  bp
);

    localparam int bw = cpuPkg::byteW;

    logic [cpuPkg::dataW-1:0] regs [8];             // AX CX DX BX SP BP SI DI
    cpuPkg::regIdxT byteIdx;                        // AL..BL and AH..BH share AX..BX

    assign byteIdx = {1'b0, rp.idx[1:0]};

    // Read ------------------------------
    always_comb begin
        if (rp.wide) rp.rdValue = regs[rp.idx];
        else if (rp.idx[2]) rp.rdValue = {{bw{1'b0}}, regs[byteIdx][2*bw-1:bw]};
        else rp.rdValue = {{bw{1'b0}}, regs[byteIdx][bw-1:0]};
    end

    // Write on the rising edge
    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) begin
            for (int k = 0; k < 8; k++) regs[k] <= cpuPkg::regReset[k];
        end else if (rp.wrEn) begin
            if (rp.wide) regs[rp.idx] <= rp.wrValue;
            else if (rp.idx[2]) regs[byteIdx][2*bw-1:bw] <= rp.wrValue[bw-1:0];
            else regs[byteIdx][bw-1:0] <= rp.wrValue[bw-1:0];
        end
    end

    // Pointers for the address unit
    assign bx = regs[cpuPkg::regBx];
    assign si = regs[cpuPkg::regSi];
    assign di = regs[cpuPkg::regDi];
    assign bp = regs[cpuPkg::regBp];

endmodule

`default_nettype wire

/* rtl/sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module sequencer (
    input  logic                      clk25,
    input  logic                      arstN,
    input  logic [cpuPkg::byteW-1:0]  rdData,
    regPortIf.ctrl                    rp,
    aluCtrlIf.ctrl                    ac,
    output logic                      ipStep,
    output logic                      eaLoad,
    output logic                      eaStep,
    output logic                      eaBack,
    output logic                      useEa,
    output cpuPkg::regIdxT            rmField,
    output logic                      wrEn
);

    logic [3:0]                 state;
    logic [3:0]                 nextState;
    logic [cpuPkg::byteW-1:0]   opcode;
    logic [cpuPkg::byteW-1:0]   modrm;
    logic isAluRm;                                  // Latched opcode decode
    logic isAccImm;
    logic fetchAluRm;                               // Decode of the byte on the bus
    logic fetchAccImm;
    logic regOp;                                    // mod = 11
    logic memDest;
    logic isCmp;
    cpuPkg::regIdxT destIdx;

    // Decode ----------------------------
    assign isAluRm     = (opcode & cpuPkg::aluRmMask) == cpuPkg::aluRmVal;
    assign isAccImm    = (opcode & cpuPkg::accImmMask) == cpuPkg::accImmVal;
    assign fetchAluRm  = (rdData & cpuPkg::aluRmMask) == cpuPkg::aluRmVal;
    assign fetchAccImm = (rdData & cpuPkg::accImmMask) == cpuPkg::accImmVal;
    assign regOp       = modrm[7:6] == cpuPkg::modReg;
    assign isCmp       = ac.op == aluPkg::aluCmp;
    assign memDest     = isAluRm && !regOp && !ac.dir;
    assign destIdx     = isAccImm ? cpuPkg::regAx : (ac.dir ? modrm[5:3] : modrm[2:0]);

    assign ac.op   = opcode[5:3];
    assign ac.wide = opcode[0];                     // w bit
    assign ac.dir  = isAccImm | opcode[1];          // Accumulator is always destination
    assign rp.wide = opcode[0];
    assign rmField = modrm[2:0];

    always_ff @(posedge clk25 or negedge arstN) begin
        if (!arstN) begin
            state  <= cpuPkg::stFetch;
            opcode <= '0;
            modrm  <= '0;
        end else begin
            state <= nextState;
            if (state == cpuPkg::stFetch) opcode <= rdData;
            if (state == cpuPkg::stModrm) modrm <= rdData;
        end
    end

    // Step control ----------------------
    always_comb begin
        nextState   = state;
        ipStep      = 1'b0;
        eaLoad      = 1'b0;
        eaStep      = 1'b0;
        eaBack      = 1'b0;
        useEa       = 1'b0;
        wrEn        = 1'b0;
        rp.idx      = modrm[5:3];                   // reg field unless told otherwise
        rp.wrEn     = 1'b0;
        ac.loadLow  = 1'b0;
        ac.loadHigh = 1'b0;
        ac.loadReg  = 1'b0;
        ac.commit   = 1'b0;
        ac.wrHigh   = 1'b0;
        case (state)
            cpuPkg::stFetch: begin
                ipStep = 1'b1;
                if (fetchAluRm) nextState = cpuPkg::stModrm;
                else if (fetchAccImm) nextState = cpuPkg::stImmLow;
                // Anything else passes as a one byte no-op
            end
            cpuPkg::stModrm: begin
                ipStep    = 1'b1;
                nextState = cpuPkg::stOpReg;
            end
            cpuPkg::stOpReg: begin
                ac.loadReg = 1'b1;
                eaLoad     = !regOp;                // Pair sum for the rm field
                nextState  = regOp ? cpuPkg::stOpRm : cpuPkg::stOpLow;
            end
            cpuPkg::stOpRm: begin
                rp.idx      = modrm[2:0];
                ac.loadLow  = 1'b1;                 // Whole register word
                ac.loadHigh = 1'b1;
                nextState   = cpuPkg::stExec;
            end
            cpuPkg::stOpLow: begin
                useEa      = 1'b1;
                ac.loadLow = 1'b1;
                eaStep     = ac.wide;
                nextState  = ac.wide ? cpuPkg::stOpHigh : cpuPkg::stExec;
            end
            cpuPkg::stOpHigh: begin
                useEa       = 1'b1;
                ac.loadHigh = 1'b1;
                eaBack      = 1'b1;                 // Back to ea for write-back
                nextState   = cpuPkg::stExec;
            end
            cpuPkg::stExec: begin
                rp.idx = destIdx;
                if (memDest && !isCmp) begin
                    nextState = cpuPkg::stWrLow;    // Flags wait for the last byte
                end else begin
                    ac.commit = 1'b1;
                    rp.wrEn   = !isCmp;
                    nextState = cpuPkg::stFetch;
                end
            end
            cpuPkg::stWrLow: begin
                useEa     = 1'b1;
                wrEn      = 1'b1;
                ac.commit = !ac.wide;
                eaStep    = ac.wide;
                nextState = ac.wide ? cpuPkg::stWrHigh : cpuPkg::stFetch;
            end
            cpuPkg::stWrHigh: begin
                useEa     = 1'b1;
                wrEn      = 1'b1;
                ac.wrHigh = 1'b1;
                ac.commit = 1'b1;
                nextState = cpuPkg::stFetch;
            end
            cpuPkg::stImmLow: begin
                rp.idx     = cpuPkg::regAx;         // AL or AX
                ac.loadReg = 1'b1;
                ac.loadLow = 1'b1;
                ipStep     = 1'b1;
                nextState  = ac.wide ? cpuPkg::stImmHigh : cpuPkg::stExec;
            end
            cpuPkg::stImmHigh: begin
                ac.loadHigh = 1'b1;
                ipStep      = 1'b1;
                nextState   = cpuPkg::stExec;
            end
            default: nextState = cpuPkg::stFetch;
        endcase
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the CPU testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tbCpu -f verilog.f -o simCpu > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/simCpu > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulator returned status $simStatus"
    exit 1
fi
exit 0

/* verif/cpuTop_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuTopProperties (
    input logic        clk25,
    input logic        arstN,
    input logic [15:0] addr,
    input logic [7:0]  wrData,
    input logic        wrEn
);

    // Bus quiet in reset and in the first cycle out of it
    wrQuietInReset: assert property (@(posedge clk25) !arstN |-> !wrEn)
        else $error("write strobe during reset");
    wrQuietAfterReset: assert property (@(posedge clk25) $rose(arstN) |-> !wrEn)
        else $error("write strobe in first cycle after reset");

    // Word write-back ------------------
    wrAddrSteps: assert property (@(posedge clk25) disable iff (!arstN)
        wrEn && $past(wrEn) |-> addr == $past(addr) + 16'd1)
        else $error("back to back writes not at consecutive addresses");

    wrDataKnown: assert property (@(posedge clk25) disable iff (!arstN)
        wrEn |-> !$isunknown(wrData))
        else $error("write data unknown");

endmodule

bind cpuTop cpuTopProperties uProps (.clk25, .arstN, .addr, .wrData, .wrEn);

`default_nettype wire

/* verif/tbCpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tbCpu;

    logic        clk25;
    logic        arstN;
    logic [7:0]  rdData;
    logic [15:0] addr;
    logic [7:0]  wrData;
    logic        wrEn;

    logic [7:0]  mem [0:65535];                     // Bus memory
    logic [7:0]  modelMem [0:65535];                // Memory as the model sees it
    logic        touched [0:65535];                 // Read or written by some instruction
    logic [15:0] regs [8];                          // Model AX CX DX BX SP BP SI DI
    logic        cf;
    logic [15:0] pc;                                // Program build pointer
    logic [15:0] expAddr [$];
    logic [7:0]  expData [$];
    string       expName [$];
    int          numInstr;
    int          cycles;
    int          timeLimit;
    logic        started;

    cpuTop u_cpuTop (.clk25, .arstN, .rdData, .addr, .wrData, .wrEn);

    assign rdData = mem[addr];                      // Combinational read

    initial begin
        clk25 = 1'b0;
        forever #50 clk25 = ~clk25;
    end

    task automatic failRun();
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    // Checks ----------------------------
    always @(posedge clk25) begin
        if (arstN) begin
            cycles <= cycles + 1;
            if (!started) begin
                started <= 1'b1;
                assert (addr == 16'hFFF0) else begin
                    $display("Fail first fetch: expected %h, actual %h", 16'hFFF0, addr);
                    failRun();
                end
            end
            if (cycles > timeLimit) begin
                $display("timed out waiting for instructions");
                failRun();
            end
            if (wrEn) begin
                assert (expAddr.size() > 0) else begin
                    $display("Memory write at %h that no instruction should make", addr);
                    failRun();
                end
                assert (addr == expAddr[0] && wrData == expData[0]) begin
                    mem[addr] <= wrData;
                    void'(expAddr.pop_front());
                    void'(expData.pop_front());
                    void'(expName.pop_front());
                end else begin
                    $display("Fail %s: expected %h at %h, actual %h at %h",
                        expName[0], expData[0], expAddr[0], wrData, addr);
                    failRun();
                end
            end
        end
    end

    // Instruction model -----------------
    function automatic logic [15:0] readReg(logic [2:0] idx, logic w);
        if (w) return regs[idx];
        if (idx[2]) return {8'h00, regs[{1'b0, idx[1:0]}][15:8]};   // AH..BH
        return {8'h00, regs[{1'b0, idx[1:0]}][7:0]};
    endfunction

    task automatic writeReg(logic [2:0] idx, logic w, logic [15:0] v);
        if (w) regs[idx] = v;
        else if (idx[2]) regs[{1'b0, idx[1:0]}][15:8] = v[7:0];
        else regs[{1'b0, idx[1:0]}][7:0] = v[7:0];
    endtask

    // x86 result with CF in bit 16
    function automatic logic [16:0] calc(logic [2:0] op, logic w, logic [15:0] a,
                                         logic [15:0] b);
        logic [16:0] mask;
        logic [16:0] x;
        logic [16:0] y;
        logic [16:0] c0;
        logic [16:0] full;
        logic        c;
        mask = w ? 17'h0FFFF : 17'h000FF;
        x = {1'b0, a};
        y = {1'b0, b};
        c0 = {16'd0, cf};
        case (op)
            3'd0:    full = x + y;
            3'd1:    full = x | y;
            3'd2:    full = x + y + c0;
            3'd3:    full = x - y - c0;
            3'd4:    full = x & y;
            3'd6:    full = x ^ y;
            default: full = x - y;                  // SUB, CMP
        endcase
        case (op)
            3'd0, 3'd2: c = full > mask;            // Carry out of the width
            3'd3:       c = (y + c0) > x;           // Borrow
            3'd5, 3'd7: c = y > x;
            default:    c = 1'b0;                   // Logic ops clear CF
        endcase
        full = full & mask;
        return {c, full[15:0]};
    endfunction

    function automatic logic [15:0] eaOf(logic [2:0] rm);
        case (rm)
            3'd0: return regs[3] + regs[6];         // bx+si
            3'd1: return regs[3] + regs[7];
            3'd2: return regs[5] + regs[6];
            3'd3: return regs[5] + regs[7];         // bp+di
            3'd4: return regs[6];
            3'd5: return regs[7];
            default: return regs[3];
        endcase
    endfunction

    // Clear of the program at FFF0 and up from 0000
    function automatic logic safeEa(logic [15:0] ea);
        return ea >= 16'h1000 && ea <= 16'hFFD0;
    endfunction

    task automatic putByte(logic [7:0] b);
        mem[pc] = b;
        modelMem[pc] = b;
        pc = pc + 16'd1;
    endtask

    task automatic expectWrite(string name, logic [15:0] a, logic [7:0] v);
        expAddr.push_back(a);
        expData.push_back(v);
        expName.push_back(name);
        modelMem[a] = v;
        touched[a] = 1'b1;
    endtask

    task automatic aluRm(string name, logic [2:0] op, logic d, logic w, logic [7:0] modrm);
        logic [7:0]  mr;
        logic [15:0] ea;
        logic [15:0] rv;
        logic [15:0] mv;
        logic [16:0] r;
        mr = modrm;
        if (mr[7:6] == 2'b00 && mr[2:0] == 3'd6) mr[2:0] = 3'd4;    // No direct mode
        ea = eaOf(mr[2:0]);
        if (mr[7:6] != 2'b11 && !safeEa(ea)) mr[7:6] = 2'b11;      // Keep off the code
        putByte({2'b00, op, 1'b0, d, w});
        putByte(mr);
        numInstr++;
        rv = readReg(mr[5:3], w);
        if (mr[7:6] == 2'b11) mv = readReg(mr[2:0], w);
        else begin
            mv = w ? {modelMem[ea + 16'd1], modelMem[ea]} : {8'h00, modelMem[ea]};
            touched[ea] = 1'b1;                     // Memory operand fixed from here on
            touched[ea + 16'd1] = 1'b1;
        end
        r = d ? calc(op, w, rv, mv) : calc(op, w, mv, rv);
        cf = r[16];
        if (op != 3'd7) begin                       // CMP writes nothing
            if (d) writeReg(mr[5:3], w, r[15:0]);
            else if (mr[7:6] == 2'b11) writeReg(mr[2:0], w, r[15:0]);
            else begin
                expectWrite(name, ea, r[7:0]);      // Low byte first
                if (w) expectWrite(name, ea + 16'd1, r[15:8]);
            end
        end
    endtask

    task automatic accImm(string name, logic [2:0] op, logic w, logic [15:0] imm);
        logic [16:0] r;
        putByte({2'b00, op, 2'b10, w});
        putByte(imm[7:0]);
        if (w) putByte(imm[15:8]);
        numInstr++;
        r = calc(op, w, readReg(3'd0, w), w ? imm : {8'h00, imm[7:0]});
        cf = r[16];
        if (op != 3'd7) writeReg(3'd0, w, r[15:0]);
    endtask

    // Register out to [si] through XOR
    task automatic observe(string name, logic [2:0] idx);
        logic [15:0] ea;
        ea = regs[6];
        if (safeEa(ea)) begin
            if (!touched[ea] && !touched[ea + 16'd1]) begin
                mem[ea] = 8'h00;
                mem[ea + 16'd1] = 8'h00;
                modelMem[ea] = 8'h00;
                modelMem[ea + 16'd1] = 8'h00;
            end
            aluRm(name, 3'd6, 1'b0, 1'b1, {2'b00, idx, 3'd4});
        end
    endtask

    // Program and run -------------------
    initial begin
        int seedVal;
        int kind;
        logic [15:0] endPc;
        seedVal = $urandom(32'h3829087e);
        arstN = 1'b0;
        cycles = 0;
        timeLimit = 1000;
        started = 1'b0;
        numInstr = 0;
        cf = 1'b0;
        for (logic [16:0] a = 0; a < 17'h10000; a++) begin
            mem[a[15:0]] = a[7:0] ^ a[15:8] ^ 8'h5A;   // Pattern over the whole address
            modelMem[a[15:0]] = a[7:0] ^ a[15:8] ^ 8'h5A;
            touched[a[15:0]] = 1'b0;
        end
        regs = '{16'h0605, 16'h1245, 16'h64EA, 16'hE004,
                 16'h0000, 16'h0000, 16'h1234, 16'h0000};
        pc = 16'hFFF0;

        observe("reset AX", 3'd0);
        observe("reset SI", 3'd6);
        aluRm("add word d1", 3'd0, 1'b1, 1'b1, 8'hCA);  // CX += DX
        aluRm("or byte d0", 3'd1, 1'b0, 1'b0, 8'hE3);   // BL |= AH
        aluRm("and byte d1", 3'd4, 1'b1, 1'b0, 8'hF9);  // BH &= CL
        aluRm("xor word d0", 3'd6, 1'b0, 1'b1, 8'hD1);  // CX ^= DX
        aluRm("sub byte d1", 3'd5, 1'b1, 1'b0, 8'hE8);  // CH -= AL
        observe("reg CX", 3'd1);
        observe("reg BX", 3'd3);
        aluRm("set bp", 3'd0, 1'b1, 1'b1, 8'hEE);
        aluRm("set di", 3'd1, 1'b1, 1'b1, 8'hF9);
        aluRm("mem add word bx+si", 3'd0, 1'b0, 1'b1, 8'h08);
        aluRm("mem xor byte bp+di", 3'd6, 1'b0, 1'b0, 8'h13);
        aluRm("mem or word si", 3'd1, 1'b0, 1'b1, 8'h1C);
        aluRm("mem sub read", 3'd5, 1'b1, 1'b1, 8'h00);
        observe("mem read AX", 3'd0);
        accImm("add carry", 3'd0, 1'b1, 16'hFFFF);
        aluRm("adc word", 3'd2, 1'b1, 1'b1, 8'hC3);
        observe("adc AX", 3'd0);
        aluRm("sub byte", 3'd5, 1'b1, 1'b0, 8'hC1);     // AL -= CL with borrow
        aluRm("sbb byte", 3'd3, 1'b1, 1'b0, 8'hD1);
        observe("sbb DX", 3'd2);
        accImm("cmp", 3'd7, 1'b1, 16'hFFFF);
        aluRm("adc after cmp", 3'd2, 1'b1, 1'b1, 8'hD8);
        observe("cmp carry BX", 3'd3);
        accImm("and imm8", 3'd4, 1'b0, 16'h005A);
        accImm("xor imm16", 3'd6, 1'b1, 16'hA5C3);
        observe("imm AX", 3'd0);

        for (int k = 0; k < 200; k++) begin
            kind = $urandom_range(3, 0);
            if (kind == 0) begin
                accImm("random imm", 3'($urandom_range(7, 0)), 1'($urandom_range(1, 0)),
                       16'($urandom()));
            end else begin
                aluRm("random rm", 3'($urandom_range(7, 0)), 1'($urandom_range(1, 0)),
                      1'($urandom_range(1, 0)),
                      {($urandom_range(1, 0) == 1) ? 2'b11 : 2'b00, 6'($urandom())});
            end
            if (k % 10 == 9) observe("random observe", 3'($urandom_range(7, 0)));
        end
        observe("final AX", 3'd0);

        endPc = pc;
        for (int k = 0; k < 8; k++) putByte(8'h90);  // One byte no-ops
        timeLimit = 8 * numInstr + 50;

        repeat (8) @(posedge clk25);
        arstN <= 1'b1;
        @(negedge clk25);
        while (!(addr == endPc && expAddr.size() == 0)) @(negedge clk25);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
rtl/cpuPkg.sv
rtl/aluPkg.sv
rtl/cpuIfs.sv
rtl/sequencer.sv
rtl/addressUnit.sv
rtl/regFile.sv
rtl/aluUnit.sv
rtl/cpuTop.sv
verif/cpuTop_properties.sv
verif/tbCpu.sv
